/* build.f */
+incdir+include
logic/rec_buf_pkg.sv
logic/rec_wr_map.sv
logic/rec_bank_array.sv
logic/rec_rd_map.sv
logic/rec_buf_top.sv
test/rec_buf_tb.sv

/* Bender.yml */
package:
  name: rec_buf

sources:
  - files:
      - logic/rec_buf_pkg.sv
      - logic/rec_wr_map.sv
      - logic/rec_bank_array.sv
      - logic/rec_rd_map.sv
      - logic/rec_buf_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - test/rec_buf_tb.sv

/* include/rec_buf_tb_cases.svh */
// stimulus table for the reconstruction buffer testbench
`ifndef REC_BUF_TB_CASES_SVH
`define REC_BUF_TB_CASES_SVH

// columns: op, name, plane, size, x4, y4, idx, repeat, x4 step, idx step, seed
task automatic load_cases();
  // one row per size, read straight back
  add_case(OP_WR, "y08_wr", PY, S08, 4'd0, 4'd0, 5'd0, 1, 0, 0, 16'h0101);
  add_case(OP_RD, "y08_rd", PY, S08, 4'd0, 4'd0, 5'd0, 1, 0, 0, 16'h0000);
  add_case(OP_WR, "y16_wr", PY, S16, 4'd8, 4'd0, 5'd3, 1, 0, 0, 16'h0202);
  add_case(OP_RD, "y16_rd", PY, S16, 4'd8, 4'd0, 5'd3, 1, 0, 0, 16'h0000);
  add_case(OP_WR, "y32_wr", PY, S32, 4'd0, 4'd8, 5'd7, 1, 0, 0, 16'h0303);
  add_case(OP_RD, "y32_rd", PY, S32, 4'd0, 4'd8, 5'd7, 1, 0, 0, 16'h0000);

  // same position on all three planes
  add_case(OP_WR, "pl_y_wr", PY, S32, 4'd0, 4'd0, 5'd5, 1, 0, 0, 16'h1111);
  add_case(OP_WR, "pl_u_wr", PU, S32, 4'd0, 4'd0, 5'd5, 1, 0, 0, 16'h2222);
  add_case(OP_WR, "pl_v_wr", PV, S32, 4'd0, 4'd0, 5'd5, 1, 0, 0, 16'h3333);
  add_case(OP_RD, "pl_y_rd", PY, S32, 4'd0, 4'd0, 5'd5, 1, 0, 0, 16'h0000);
  add_case(OP_RD, "pl_u_rd", PU, S32, 4'd0, 4'd0, 5'd5, 1, 0, 0, 16'h0000);
  add_case(OP_RD, "pl_v_rd", PV, S32, 4'd0, 4'd0, 5'd5, 1, 0, 0, 16'h0000);

  // full idx sweep of a 32 block, x4 sweep of an 8 row
  add_case(OP_WR, "sw32_wr", PY, S32, 4'd8, 4'd8, 5'd0, 32, 0, 1, 16'h4400);
  add_case(OP_RD, "sw32_rd", PY, S32, 4'd8, 4'd8, 5'd0, 32, 0, 1, 16'h0000);
  add_case(OP_WR, "sw08_wr", PY, S08, 4'd8, 4'd4, 5'd0, 4, 2, 0, 16'h5500);
  add_case(OP_RD, "sw08_rd", PY, S08, 4'd8, 4'd4, 5'd0, 4, 2, 0, 16'h0000);

  // 16 blocks read back as 8 rows
  add_case(OP_WR, "b16a_wr", PU, S16, 4'd0, 4'd0, 5'd0, 16, 0, 1, 16'h6600);
  add_case(OP_WR, "b16b_wr", PU, S16, 4'd4, 4'd0, 5'd0, 16, 0, 1, 16'h7700);
  add_case(OP_RD, "x8a_rd", PU, S08, 4'd0, 4'd0, 5'd0, 4, 2, 0, 16'h0000);
  add_case(OP_RD, "x8b_rd", PU, S08, 4'd0, 4'd0, 5'd4, 4, 2, 0, 16'h0000);
  add_case(OP_RD, "x8c_rd", PU, S08, 4'd0, 4'd2, 5'd0, 4, 2, 0, 16'h0000);
  add_case(OP_RD, "x8d_rd", PU, S08, 4'd0, 4'd2, 5'd4, 4, 2, 0, 16'h0000);

  // read and write in one cycle, the write must be dropped
  add_collide("coll", PY, S08, 4'd0, 4'd0, 5'd0, PY, S32, 4'd0, 4'd0, 5'd5, 16'h8888);
  add_case(OP_RD, "coll_chk", PY, S08, 4'd0, 4'd0, 5'd0, 1, 0, 0, 16'h0000);

  // output holds over idle cycles
  add_case(OP_IDLE, "hold", PY, S08, 4'd0, 4'd0, 5'd0, 6, 0, 0, 16'h0000);
endtask

`endif

/* test/rec_buf_tb.sv */
// testbench for the reconstruction pixel buffer, table driven with a bank level model
`timescale 1ns/1ns
`default_nettype none

module rec_buf_tb;

  localparam int PIXEL_W = 8;
  localparam int SEG_W   = rec_buf_pkg::SEG_PIX * PIXEL_W;

  localparam int OP_WR   = 0;
  localparam int OP_RD   = 1;
  localparam int OP_WRRD = 2;
  localparam int OP_IDLE = 3;

  localparam rec_buf_pkg::plane_e    PY  = rec_buf_pkg::PLANE_Y;
  localparam rec_buf_pkg::plane_e    PU  = rec_buf_pkg::PLANE_U;
  localparam rec_buf_pkg::plane_e    PV  = rec_buf_pkg::PLANE_V;
  localparam rec_buf_pkg::blk_size_e S08 = rec_buf_pkg::SIZE_08;
  localparam rec_buf_pkg::blk_size_e S16 = rec_buf_pkg::SIZE_16;
  localparam rec_buf_pkg::blk_size_e S32 = rec_buf_pkg::SIZE_32;

  typedef logic [rec_buf_pkg::ROW_PIX-1:0][PIXEL_W-1:0] row_t;

  typedef struct packed {
    logic [1:0]            op;
    rec_buf_pkg::buf_cmd_t cmd;
    rec_buf_pkg::buf_cmd_t rcmd;
    logic [15:0]           seed;
    logic [5:0]            rep;
    logic [3:0]            dx;
    logic [3:0]            di;
  } case_t;

  logic                  clk;
  logic                  rstn;
  rec_buf_pkg::buf_cmd_t wr_cmd;
  rec_buf_pkg::buf_cmd_t rd_cmd;
  row_t                  wr_dat;
  row_t                  rd_dat;

  case_t            cases[$];
  string            names[$];
  logic [SEG_W-1:0] model[int];
  int               seed_v = 32'h9c3f;
  int               err_cnt = 0;
  row_t             last_row;

  // segment position to bank, one table per size
  int perm8  [4][4] = '{'{0, 1, 2, 3}, '{2, 3, 0, 1}, '{1, 2, 3, 0}, '{3, 0, 1, 2}};
  int perm16 [4][4] = '{'{0, 2, 1, 3}, '{2, 0, 3, 1}, '{1, 3, 2, 0}, '{3, 1, 0, 2}};
  int perm32 [4][4] = '{'{0, 2, 1, 3}, '{1, 3, 2, 0}, '{2, 0, 3, 1}, '{3, 1, 0, 2}};
  int rot8   [4]    = '{0, 2, 3, 1};

  rec_buf_top #(
    .PIXEL_W (PIXEL_W)
  ) uut (
    .clk      (clk),
    .rstn     (rstn),
    .wr_cmd_i (wr_cmd),
    .wr_dat_i (wr_dat),
    .rd_cmd_i (rd_cmd),
    .rd_dat_o (rd_dat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_now(string msg);
    err_cnt++;
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // watchdog for the whole run
  initial begin
    for (int w = 0; w < 400; w++) begin
      #100;
    end
    fail_now("simulation ran past its time limit");
  end

  task automatic wait_edge();
    int n;
    bit got;
    n = 0;
    got = 0;
    while (!got && n < 4) begin
      @(clk);
      n++;
      if (clk === 1'b1) got = 1;
    end
    if (!got) fail_now("clock stopped toggling");
  endtask

  function automatic string cmd_str(rec_buf_pkg::buf_cmd_t c);
    return $sformatf("(pl %0d sz %0d x4 %0d y4 %0d idx %0d)",
                     c.plane, c.size, c.x4, c.y4, c.idx);
  endfunction

  task automatic check_row(string name, rec_buf_pkg::buf_cmd_t c, row_t exp, row_t act);
    if (act !== exp) begin
      fail_now($sformatf("error %s %s expected %h actual %h", name, cmd_str(c), exp, act));
    end
  endtask

  task automatic check_ctl(string name, rec_buf_pkg::bank_ctl_t exp,
                           rec_buf_pkg::bank_ctl_t act);
    if (act !== exp) begin
      fail_now($sformatf("error %s bank ctl expected %h actual %h", name, exp, act));
    end
  endtask

  // ------------------------------------------------------------
  // reference layout
  // ------------------------------------------------------------
  function automatic int model_adr(rec_buf_pkg::buf_cmd_t c, int bank);
    int hi;
    int mi;
    int lo;
    if (c.plane == PY) hi = c.y4[3] * 2 + c.x4[3];
    else hi = 4 + c.plane[0];
    if (c.size == S08) begin
      mi = c.y4[2:1] * 2 + c.idx[2];
      lo = (bank + rot8[c.x4[2:1]]) % 4;
    end else if (c.size == S16) begin
      mi = c.y4[2] * 4 + c.idx[3:2];
      lo = c.idx[1] * 2 + (c.x4[2] ^ bank[0]);
    end else begin
      mi = c.idx[4:2];
      lo = c.idx[1:0];
    end
    return hi * 32 + mi * 4 + lo;
  endfunction

  function automatic int pos_bank(rec_buf_pkg::buf_cmd_t c, int pos);
    if (c.size == S08) return perm8[c.x4[2:1]][pos];
    if (c.size == S16) return perm16[{c.x4[2], c.idx[1]}][pos];
    return perm32[c.idx[1:0]][pos];
  endfunction

  function automatic rec_buf_pkg::bank_ctl_t model_ctl(rec_buf_pkg::buf_cmd_t c);
    rec_buf_pkg::bank_ctl_t t;
    t.ena = 1'b1;
    for (int b = 0; b < 4; b++) t.adr[b] = rec_buf_pkg::ADR_W'(model_adr(c, b));
    return t;
  endfunction

  task automatic model_write(rec_buf_pkg::buf_cmd_t c, row_t d);
    logic [rec_buf_pkg::ROW_PIX*PIXEL_W-1:0] flat;
    int b;
    flat = d;
    for (int p = 0; p < 4; p++) begin
      b = pos_bank(c, p);
      model[b * 256 + model_adr(c, b)] = flat[(3 - p) * SEG_W +: SEG_W];
    end
  endtask

  task automatic model_read(string name, rec_buf_pkg::buf_cmd_t c, output row_t r);
    logic [rec_buf_pkg::ROW_PIX*PIXEL_W-1:0] flat;
    int key;
    flat = '0;
    for (int p = 0; p < 4; p++) begin
      key = pos_bank(c, p) * 256 + model_adr(c, pos_bank(c, p));
      if (!model.exists(key)) fail_now($sformatf("%s reads a word never written", name));
      flat[(3 - p) * SEG_W +: SEG_W] = model[key];
    end
    r = flat;
  endtask

  // ------------------------------------------------------------
  // table
  // ------------------------------------------------------------
  task automatic add_case(int op, string name, rec_buf_pkg::plane_e pl,
                          rec_buf_pkg::blk_size_e sz, logic [3:0] x4, logic [3:0] y4,
                          logic [4:0] idx, int rep, int dx, int di, logic [15:0] seed);
    case_t t;
    t = '0;
    t.op = 2'(op);
    t.cmd = {1'b1, pl, sz, x4, y4, idx};
    t.seed = seed;
    t.rep = 6'(rep);
    t.dx = 4'(dx);
    t.di = 4'(di);
    cases.push_back(t);
    names.push_back(name);
  endtask

  task automatic add_collide(string name, rec_buf_pkg::plane_e wpl,
                             rec_buf_pkg::blk_size_e wsz, logic [3:0] wx, logic [3:0] wy,
                             logic [4:0] widx, rec_buf_pkg::plane_e rpl,
                             rec_buf_pkg::blk_size_e rsz, logic [3:0] rx, logic [3:0] ry,
                             logic [4:0] ridx, logic [15:0] seed);
    add_case(OP_WRRD, name, wpl, wsz, wx, wy, widx, 1, 0, 0, seed);
    cases[$].rcmd = {1'b1, rpl, rsz, rx, ry, ridx};
  endtask

  `include "rec_buf_tb_cases.svh"

  task automatic run_step(case_t t, string name, int s);
    rec_buf_pkg::buf_cmd_t wc;
    rec_buf_pkg::buf_cmd_t rc;
    row_t d;
    row_t exp;
    int px;
    wc = t.cmd;
    wc.x4 = t.cmd.x4 + 4'(s * t.dx);
    wc.idx = t.cmd.idx + 5'(s * t.di);
    rc = (t.op == OP_WRRD) ? t.rcmd : wc;
    for (int k = 0; k < rec_buf_pkg::ROW_PIX; k++) begin
      px = $random(seed_v);
      d[k] = PIXEL_W'(px ^ t.seed);
    end
    wait_edge();
    #1;
    if (t.op == OP_IDLE) begin
      check_row(name, rc, last_row, rd_dat);
      return;
    end
    if (t.op != OP_RD) begin
      wr_cmd = wc;
      wr_dat = d;
    end
    if (t.op != OP_WR) begin
      rd_cmd = rc;
    end
    // let the address logic settle before looking at it
    #1;
    if (t.op != OP_WR) begin
      model_read(name, rc, exp);
      check_ctl(name, model_ctl(rc), uut.rd_ctl);
    end else begin
      check_ctl(name, model_ctl(wc), uut.wr_ctl);
      model_write(wc, d);
    end
    wait_edge();
    #1;
    wr_cmd = '0;
    rd_cmd = '0;
    if (t.op != OP_WR) begin
      check_row(name, rc, exp, rd_dat);
      last_row = exp;
    end
  endtask

  initial begin
    rstn = 1'b0;
    wr_cmd = '0;
    rd_cmd = '0;
    wr_dat = '0;
    load_cases();
    for (int i = 0; i < 16; i++) wait_edge();
    #1;
    rstn = 1'b1;
    foreach (cases[i]) begin
      for (int s = 0; s < cases[i].rep; s++) begin
        run_step(cases[i], $sformatf("%s_%0d", names[i], s), s);
      end
    end
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/rec_buf_top.sv */
// reconstruction pixel buffer, row write and row read over four banks
`timescale 1ns/1ns
`default_nettype none

module rec_buf_top #(
  parameter int PIXEL_W = 8
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  rec_buf_pkg::buf_cmd_t wr_cmd_i,
  input  logic [rec_buf_pkg::ROW_PIX-1:0][PIXEL_W-1:0] wr_dat_i,
  input  rec_buf_pkg::buf_cmd_t rd_cmd_i,
  output logic [rec_buf_pkg::ROW_PIX-1:0][PIXEL_W-1:0] rd_dat_o
);

  // ---------------------------------------------------------
  // internal buses
  // ---------------------------------------------------------
  rec_buf_pkg::bank_ctl_t wr_ctl;
  rec_buf_pkg::bank_ctl_t rd_ctl;

  // rotated write segments and raw bank words
  logic [rec_buf_pkg::BANK_NUM-1:0][rec_buf_pkg::SEG_PIX*PIXEL_W-1:0] wr_seg;
  logic [rec_buf_pkg::BANK_NUM-1:0][rec_buf_pkg::SEG_PIX*PIXEL_W-1:0] bank_seg;

  rec_wr_map #(
    .PIXEL_W (PIXEL_W)
  ) u_wr_map (
    .wr_cmd_i (wr_cmd_i),
    .wr_dat_i (wr_dat_i),
    .wr_ctl_o (wr_ctl),
    .wr_seg_o (wr_seg)
  );

  rec_bank_array #(
    .PIXEL_W (PIXEL_W)
  ) u_bank_array (
    .clk        (clk),
    .rstn       (rstn),
    .wr_ctl_i   (wr_ctl),
    .wr_seg_i   (wr_seg),
    .rd_ctl_i   (rd_ctl),
    .bank_seg_o (bank_seg)
  );

  // read data lands one cycle after the read strobe
  rec_rd_map #(
    .PIXEL_W (PIXEL_W)
  ) u_rd_map (
    .clk        (clk),
    .rstn       (rstn),
    .rd_cmd_i   (rd_cmd_i),
    .bank_seg_i (bank_seg),
    .rd_ctl_o   (rd_ctl),
    .rd_dat_o   (rd_dat_o)
  );

endmodule

`default_nettype wire

/* logic/rec_rd_map.sv */
// read side mapper, bank addressing and reorder of bank words into a row
`timescale 1ns/1ns
`default_nettype none

module rec_rd_map #(
  parameter int PIXEL_W = 8
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  rec_buf_pkg::buf_cmd_t  rd_cmd_i,
  input  logic [rec_buf_pkg::BANK_NUM-1:0][rec_buf_pkg::SEG_PIX*PIXEL_W-1:0] bank_seg_i,
  output rec_buf_pkg::bank_ctl_t rd_ctl_o,
  output logic [rec_buf_pkg::ROW_PIX-1:0][PIXEL_W-1:0] rd_dat_o
);

  localparam int SEG_W = rec_buf_pkg::SEG_PIX * PIXEL_W;

  // command fields kept for the cycle the bank words come back
  rec_buf_pkg::blk_size_e size_q;
  logic [3:0]             x4_q;
  logic [4:0]             idx_q;

  logic [rec_buf_pkg::BANK_NUM-1:0][SEG_W-1:0] row_seg;

  // ---------------------------------------------------------
  // bank addresses
  // ---------------------------------------------------------
  always_comb begin
    rd_ctl_o.ena = rd_cmd_i.ena;
    for (int b = 0; b < rec_buf_pkg::BANK_NUM; b++) begin
      rd_ctl_o.adr[b] = rec_buf_pkg::bank_adr(rd_cmd_i, 2'(b));
    end
  end

  // ---------------------------------------------------------
  // command register
  // ---------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      size_q <= rec_buf_pkg::SIZE_08;
      x4_q   <= 4'd0;
      idx_q  <= 5'd0;
    end else if (rd_cmd_i.ena) begin
      size_q <= rd_cmd_i.size;
      x4_q   <= rd_cmd_i.x4;
      idx_q  <= rd_cmd_i.idx;
    end
  end

  // ---------------------------------------------------------
  // reorder
  // ---------------------------------------------------------
  // inverse of the write rotation, same table read the other way
  always_comb begin
    for (int p = 0; p < rec_buf_pkg::BANK_NUM; p++) begin
      row_seg[rec_buf_pkg::BANK_NUM-1-p] =
        bank_seg_i[rec_buf_pkg::seg_bank(size_q, x4_q, idx_q, 2'(p))];
    end
  end

  assign rd_dat_o = row_seg;

  rd_size_ok: assert property (@(posedge clk) disable iff (!rstn)
    rd_cmd_i.ena |-> (rd_cmd_i.size != rec_buf_pkg::SIZE_04))
    else $error("read command with 4x4 block size");

endmodule

`default_nettype wire

/* logic/rec_bank_array.sv */
// four single-port pixel banks, read wins over a colliding write
`timescale 1ns/1ns
`default_nettype none

module rec_bank_array #(
  parameter int PIXEL_W = 8
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  rec_buf_pkg::bank_ctl_t wr_ctl_i,
  input  logic [rec_buf_pkg::BANK_NUM-1:0][rec_buf_pkg::SEG_PIX*PIXEL_W-1:0] wr_seg_i,
  input  rec_buf_pkg::bank_ctl_t rd_ctl_i,
  output logic [rec_buf_pkg::BANK_NUM-1:0][rec_buf_pkg::SEG_PIX*PIXEL_W-1:0] bank_seg_o
);

  localparam int SEG_W = rec_buf_pkg::SEG_PIX * PIXEL_W;

  // write only goes through on a cycle without a read
  logic wr_go;

  assign wr_go = wr_ctl_i.ena & ~rd_ctl_i.ena;

  for (genvar b = 0; b < rec_buf_pkg::BANK_NUM; b++) begin : g_bank

    logic [SEG_W-1:0]              mem [rec_buf_pkg::BANK_DEPTH];
    logic [rec_buf_pkg::ADR_W-1:0] adr;
    logic [SEG_W-1:0]              rd_q;

    // single port, shared address
    assign adr = rd_ctl_i.ena ? rd_ctl_i.adr[b] : wr_ctl_i.adr[b];

    always_ff @(posedge clk) begin
      if (wr_go) begin
        mem[adr] <= wr_seg_i[b];
      end
      // output holds until the next read
      if (rd_ctl_i.ena) begin
        rd_q <= mem[adr];
      end
    end

    assign bank_seg_o[b] = rd_q;

    // ---------------------------------------------------------
    // checks
    // ---------------------------------------------------------
    adr_range: assert property (@(posedge clk) disable iff (!rstn)
      (wr_ctl_i.ena || rd_ctl_i.ena) |-> (adr < rec_buf_pkg::BANK_DEPTH))
      else $error("bank %0d address %0d beyond depth", b, adr);

  end

endmodule

`default_nettype wire

/* logic/rec_wr_map.sv */
// write side mapper, spreads one pixel row over the four banks
`timescale 1ns/1ns
`default_nettype none

module rec_wr_map #(
  parameter int PIXEL_W = 8
) (
  input  rec_buf_pkg::buf_cmd_t  wr_cmd_i,
  input  logic [rec_buf_pkg::ROW_PIX-1:0][PIXEL_W-1:0] wr_dat_i,
  output rec_buf_pkg::bank_ctl_t wr_ctl_o,
  output logic [rec_buf_pkg::BANK_NUM-1:0][rec_buf_pkg::SEG_PIX*PIXEL_W-1:0] wr_seg_o
);

  localparam int SEG_W = rec_buf_pkg::SEG_PIX * PIXEL_W;

  // row cut into segments, top segment holds the highest pixels
  logic [rec_buf_pkg::BANK_NUM-1:0][SEG_W-1:0] row_seg;

  assign row_seg = wr_dat_i;

  // ---------------------------------------------------------
  // bank addresses
  // ---------------------------------------------------------
  always_comb begin
    wr_ctl_o.ena = wr_cmd_i.ena;
    for (int b = 0; b < rec_buf_pkg::BANK_NUM; b++) begin
      wr_ctl_o.adr[b] = rec_buf_pkg::bank_adr(wr_cmd_i, 2'(b));
    end
  end

  // ---------------------------------------------------------
  // segment rotation onto banks
  // ---------------------------------------------------------
  always_comb begin
    wr_seg_o = '0;
    for (int p = 0; p < rec_buf_pkg::BANK_NUM; p++) begin
      wr_seg_o[rec_buf_pkg::seg_bank(wr_cmd_i.size, wr_cmd_i.x4, wr_cmd_i.idx, 2'(p))] =
        row_seg[rec_buf_pkg::BANK_NUM-1-p];
    end
  end

  // no 4x4 path and no fourth plane in this buffer
  always_comb begin
    if (wr_cmd_i.ena) begin
      wr_size_ok: assert final (wr_cmd_i.size != rec_buf_pkg::SIZE_04)
        else $error("write command with 4x4 block size");
      wr_plane_ok: assert final (wr_cmd_i.plane inside {rec_buf_pkg::PLANE_Y,
                                                        rec_buf_pkg::PLANE_U,
                                                        rec_buf_pkg::PLANE_V})
        else $error("write command with unknown plane %0d", wr_cmd_i.plane);
    end
  end

endmodule

`default_nettype wire

/* logic/rec_buf_pkg.sv */
// reconstruction buffer geometry, command types and bank mapping rules
`default_nettype none

package rec_buf_pkg;

  // ---------------------------------------------------------
  // buffer geometry
  // ---------------------------------------------------------
  parameter int BANK_NUM   = 4;
  parameter int SEG_PIX    = 8;
  parameter int ROW_PIX    = BANK_NUM * SEG_PIX;
  // four luma quadrants plus two chroma planes, 32 words each
  parameter int BANK_DEPTH = 192;
  parameter int ADR_W      = 8;

  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } blk_size_e;

  typedef enum logic [1:0] {
    PLANE_Y = 2'd0,
    PLANE_U = 2'd1,
    PLANE_V = 2'd2
  } plane_e;

  typedef struct packed {
    logic       ena;
    plane_e     plane;
    blk_size_e  size;
    logic [3:0] x4;
    logic [3:0] y4;
    logic [4:0] idx;
  } buf_cmd_t;

  typedef struct packed {
    logic                           ena;
    logic [BANK_NUM-1:0][ADR_W-1:0] adr;
  } bank_ctl_t;

  // ---------------------------------------------------------
  // address of one bank for a row access
  // ---------------------------------------------------------
  function automatic logic [ADR_W-1:0] bank_adr(buf_cmd_t cmd, logic [1:0] bank);
    logic [2:0] hi;
    logic [2:0] mi;
    logic [1:0] lo;
    // region select
    if (cmd.plane == PLANE_Y) begin
      hi = {1'b0, cmd.y4[3], cmd.x4[3]};
    end else begin
      hi = {2'b10, cmd.plane[0]};
    end
    case (cmd.size)
      SIZE_08: begin
        mi = {cmd.y4[2:1], cmd.idx[2]};
        // slot rotates with the 8x8 column
        case (cmd.x4[2:1])
          2'd0:    lo = bank;
          2'd1:    lo = bank + 2'd2;
          2'd2:    lo = bank + 2'd3;
          default: lo = bank + 2'd1;
        endcase
      end
      SIZE_16: begin
        mi = {cmd.y4[2], cmd.idx[3:2]};
        lo = {cmd.idx[1], cmd.x4[2] ^ bank[0]};
      end
      SIZE_32: begin
        mi = cmd.idx[4:2];
        lo = cmd.idx[1:0];
      end
      default: begin
        mi = 3'd0;
        lo = bank;
      end
    endcase
    return {hi, mi, lo};
  endfunction

  // bank holding segment position pos, position 0 is the top pixels
  function automatic logic [1:0] seg_bank(blk_size_e size, logic [3:0] x4,
                                          logic [4:0] idx, logic [1:0] pos);
    logic [3:0][1:0] map;
    case (size)
      SIZE_08: begin
        case (x4[2:1])
          2'd0:    map = {2'd0, 2'd1, 2'd2, 2'd3};
          2'd1:    map = {2'd2, 2'd3, 2'd0, 2'd1};
          2'd2:    map = {2'd1, 2'd2, 2'd3, 2'd0};
          default: map = {2'd3, 2'd0, 2'd1, 2'd2};
        endcase
      end
      SIZE_16: begin
        case ({x4[2], idx[1]})
          2'd0:    map = {2'd0, 2'd2, 2'd1, 2'd3};
          2'd1:    map = {2'd2, 2'd0, 2'd3, 2'd1};
          2'd2:    map = {2'd1, 2'd3, 2'd2, 2'd0};
          default: map = {2'd3, 2'd1, 2'd0, 2'd2};
        endcase
      end
      SIZE_32: begin
        case (idx[1:0])
          2'd0:    map = {2'd0, 2'd2, 2'd1, 2'd3};
          2'd1:    map = {2'd1, 2'd3, 2'd2, 2'd0};
          2'd2:    map = {2'd2, 2'd0, 2'd3, 2'd1};
          default: map = {2'd3, 2'd1, 2'd0, 2'd2};
        endcase
      end
      default: map = {2'd0, 2'd1, 2'd2, 2'd3};
    endcase
    return map[2'd3 - pos];
  endfunction

endpackage

`default_nettype wire
